// File: src.f
+incdir+rtl
rtl/cnn_pkg.sv
rtl/gesture_argmax.sv
rtl/score_saturation_check.sv
rtl/apb_cnn.sv
rtl/cnn_result_top.sv
bench/cnn_result_assert.sv
bench/tb_cnn_result.sv

// File: Makefile
TOP = tb_cnn_result

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f src.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

// File: bench/tb_cnn_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "cnn_params.svh"

module tb_cnn_result
    import cnn_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 4000;  // Whole suite needs a few hundred cycles

    logic       PCLK;
    logic       PRESETn;
    score_pkt_t score_in;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    logic       irq;
    int         cycle_cnt;
    logic       assert_failed;

    // Reference model state
    argmax_res_t model_res;
    score_t      model_thresh;
    logic [31:0] model_scores;
    logic [3:0]  model_mask;
    logic [15:0] model_acc;
    logic [15:0] model_rej;
    logic        model_irq;

    cnn_result_top DUT (
        .PCLK     (PCLK),
        .PRESETn  (PRESETn),
        .score_in (score_in),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .irq      (irq)
    );

    assign assert_failed = DUT.u_apb_cnn.u_cnn_result_assert.failed;

    initial begin
        PCLK = 1'b0;
        forever #2 PCLK = ~PCLK;
    end

    always @(posedge PCLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end else if (assert_failed) begin
            $display("A bound APB or irq assertion failed");
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %b actual %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_result(input string name, input argmax_res_t exp,
                                input logic [31:0] act);
        if (act[3:0] !== exp.one_hot || act[9:8] !== exp.index) begin
            $display("FAIL %0t %s expected one_hot=%b index=%0d actual one_hot=%b index=%0d",
                     $time, name, exp.one_hot, exp.index, act[3:0], act[9:8]);
            abort_run();
        end
    endtask

    task automatic step();
        @(posedge PCLK);
        #1;  // Drive just after the edge
    endtask

    function automatic logic [31:0] make_word(input int l0, input int l1, input int l2,
                                              input int l3);
        return {8'(l3), 8'(l2), 8'(l1), 8'(l0)};  // Lane 0 in the low byte
    endfunction

    function automatic logic [1:0] ref_argmax_index(input logic [31:0] w);
        logic [1:0] best;
        score_t     best_val;
        score_t     v;
        best     = 2'd0;
        best_val = w[7:0];
        for (int i = 1; i < `CNN_NUM_CLASSES; i++) begin
            v = w[8*i +: 8];
            if (v > best_val) begin
                best     = 2'(i);
                best_val = v;
            end
        end
        return best;
    endfunction

    function automatic logic [3:0] ref_sat_mask(input logic [31:0] w);
        logic [3:0] mask;
        for (int i = 0; i < `CNN_NUM_CLASSES; i++) begin
            mask[i] = (w[8*i +: 8] == 8'h7f) || (w[8*i +: 8] == 8'h80);
        end
        return mask;
    endfunction

    task automatic model_inference(input logic [31:0] w);
        logic [1:0] idx;
        logic [3:0] mask;
        score_t     top;
        idx          = ref_argmax_index(w);
        mask         = ref_sat_mask(w);
        top          = w[8*idx +: 8];
        model_scores = w;
        model_mask   = mask;
        if (mask == 4'b0000 && top >= model_thresh) begin
            model_res.valid   = 1'b1;
            model_res.one_hot = 4'b0001 << idx;
            model_res.index   = idx;
            model_res.top     = top;
            model_acc         = model_acc + 16'd1;
            model_irq         = 1'b1;
        end else begin
            model_rej = model_rej + 16'd1;
        end
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic exp_err);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        step();
        apb_req.penable = 1'b1;
        @(negedge PCLK);  // Mid access phase
        check_bit("pslverr", exp_err, apb_rsp.pslverr);
        step();
        apb_req = '0;
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                            input logic exp_err);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = addr;
        apb_req.pwdata  = 32'd0;
        step();
        apb_req.penable = 1'b1;
        @(negedge PCLK);
        data = apb_rsp.prdata;
        check_bit("pslverr", exp_err, apb_rsp.pslverr);
        step();
        apb_req = '0;
    endtask

    task automatic set_thresh(input logic [31:0] data);
        apb_write(`CNN_REG_THRESH, data, 1'b0);
        model_thresh = data[7:0];
    endtask

    // Drives one inference and waits until the registers hold it
    task automatic send_scores(input logic [31:0] w);
        score_in.valid    = 1'b1;
        score_in.word.raw = w;
        model_inference(w);
        step();
        score_in.valid = 1'b0;
        step();
    endtask

    task automatic check_regs();
        logic [31:0] rd;
        apb_read(`CNN_REG_STATUS, rd, 1'b0);
        check_word("STATUS", {27'd0, model_irq, model_mask}, rd);
        apb_read(`CNN_REG_SCORES, rd, 1'b0);
        check_word("SCORES", model_scores, rd);
        apb_read(`CNN_REG_COUNT, rd, 1'b0);
        check_word("COUNT", {model_rej, model_acc}, rd);
        apb_read(`CNN_REG_THRESH, rd, 1'b0);
        check_word("THRESH", {24'd0, model_thresh}, rd);
    endtask

    task automatic read_result();
        logic [31:0] rd;
        apb_read(`CNN_REG_RESULT, rd, 1'b0);
        check_result("RESULT", model_res, rd);
        model_irq = 1'b0;  // Read clears the interrupt
        check_bit("irq", 1'b0, irq);
    endtask

    task automatic reset_values();
        check_bit("irq", 1'b0, irq);
        check_regs();
        read_result();
    endtask

    task automatic argmax_and_accept();
        set_thresh(32'd0);
        send_scores(make_word(10, -5, 40, 3));  // Clear winner in lane 2
        check_bit("irq", 1'b1, irq);
        check_regs();
        read_result();
        send_scores(make_word(20, 50, 50, -3));  // Lanes 1 and 2 tie for the top score
        check_bit("irq", 1'b1, irq);
        check_regs();
        read_result();
        send_scores(make_word(33, 1, 2, 33));
        check_regs();
        read_result();
    endtask

    task automatic threshold_rejection();
        set_thresh(32'hABCD_1250);  // Only the low byte sticks
        check_regs();
        send_scores(make_word(70, 10, 79, 5));
        check_bit("irq", 1'b0, irq);
        check_regs();
        read_result();
        send_scores(make_word(80, 12, -40, 80));  // Exactly at threshold
        check_bit("irq", 1'b1, irq);
        check_regs();
        read_result();
    endtask

    task automatic saturation_rejection();
        send_scores(make_word(127, 100, 0, 0));
        check_bit("irq", 1'b0, irq);
        check_regs();
        send_scores(make_word(90, -128, 85, 127));
        check_regs();
        read_result();
    endtask

    task automatic back_to_back_stream();
        logic [31:0] w;
        int          v;
        int          k;
        set_thresh(32'h0000_00EC);  // -20
        for (int n = 0; n < 20; n++) begin
            for (int i = 0; i < `CNN_NUM_CLASSES; i++) begin
                v = int'($urandom_range(252)) - 126;
                w[8*i +: 8] = 8'(v);
            end
            if (n % 4 == 3) begin
                k = int'($urandom_range(3));
                w[8*k +: 8] = ($urandom_range(1) != 0) ? 8'h7f : 8'h80;
            end
            score_in.valid    = 1'b1;
            score_in.word.raw = w;
            model_inference(w);
            step();
        end
        score_in.valid = 1'b0;
        step();  // Last inference reaches the registers
        check_regs();
        read_result();
    endtask

    task automatic bus_errors();
        logic [31:0] rd;
        apb_read(12'h014, rd, 1'b1);
        check_word("prdata", 32'd0, rd);
        apb_read(12'h002, rd, 1'b1);
        check_word("prdata", 32'd0, rd);
        apb_write(`CNN_REG_RESULT, 32'hFFFF_FFFF, 1'b1);
        apb_write(`CNN_REG_SCORES, 32'h1234_5678, 1'b1);
        apb_write(`CNN_REG_COUNT,  32'hFFFF_FFFF, 1'b1);
        apb_write(`CNN_REG_STATUS, 32'h0000_001F, 1'b1);
        apb_write(12'h100, 32'h0000_0055, 1'b1);
        check_regs();
        read_result();
    endtask

    initial begin
        PRESETn      = 1'b0;
        score_in     = '0;
        apb_req      = '0;
        cycle_cnt    = 0;
        model_res    = '0;
        model_thresh = 8'sd0;
        model_scores = 32'd0;
        model_mask   = 4'b0000;
        model_acc    = 16'd0;
        model_rej    = 16'd0;
        model_irq    = 1'b0;
        void'($urandom(32'h1f2b_9491));
        repeat (4) @(posedge PCLK);
        #1;
        PRESETn = 1'b1;
        step();

        reset_values();
        argmax_and_accept();
        threshold_rejection();
        saturation_rejection();
        back_to_back_stream();
        bus_errors();

        if (assert_failed) begin
            $display("A bound APB or irq assertion failed");
            abort_run();
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: bench/cnn_result_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cnn_result_assert
    import cnn_pkg::*;
(
    input logic     PCLK,
    input logic     PRESETn,
    input apb_req_t apb_req,
    input apb_rsp_t apb_rsp,
    input logic     irq
);

    logic access_phase;
    logic rd_access;

    logic pready_bad  = 1'b0;
    logic prdata_bad  = 1'b0;
    logic pslverr_bad = 1'b0;
    logic irq_bad     = 1'b0;
    logic failed;

    assign access_phase = apb_req.psel & apb_req.penable;
    assign rd_access    = access_phase & ~apb_req.pwrite;
    assign failed       = pready_bad | prdata_bad | pslverr_bad | irq_bad;

    // Zero wait state slave
    pready_high: assert property (@(posedge PCLK) disable iff (!PRESETn)
        apb_rsp.pready)
        else begin
            $error("pready was low");
            pready_bad = 1'b1;
        end

    prdata_idle_zero: assert property (@(posedge PCLK) disable iff (!PRESETn)
        !rd_access |-> (apb_rsp.prdata == 32'd0))
        else begin
            $error("prdata nonzero outside a read access phase");
            prdata_bad = 1'b1;
        end

    pslverr_idle_zero: assert property (@(posedge PCLK) disable iff (!PRESETn)
        !access_phase |-> !apb_rsp.pslverr)
        else begin
            $error("pslverr high outside an access phase");
            pslverr_bad = 1'b1;
        end

    irq_low_in_reset: assert property (@(posedge PCLK)
        !PRESETn |-> !irq)
        else begin
            $error("irq high during reset");
            irq_bad = 1'b1;
        end

endmodule

bind apb_cnn cnn_result_assert u_cnn_result_assert (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .irq     (irq)
);

`default_nettype wire

// File: rtl/cnn_result_top.sv
`timescale 1ns/1ps
`default_nettype none

module cnn_result_top
    import cnn_pkg::*;
(
    input  logic       PCLK,
    input  logic       PRESETn,
    input  score_pkt_t score_in,
    input  apb_req_t   apb_req,
    output apb_rsp_t   apb_rsp,
    output logic       irq
);

    argmax_res_t argmax_res;  // Winner, one cycle after inference
    sat_res_t    sat_res;     // Clip mask, same cycle as argmax_res

    gesture_argmax u_gesture_argmax (
        .PCLK     (PCLK),
        .PRESETn  (PRESETn),
        .score_in (score_in),
        .result   (argmax_res)
    );

    score_saturation_check u_score_saturation_check (
        .PCLK     (PCLK),
        .PRESETn  (PRESETn),
        .score_in (score_in),
        .result   (sat_res)
    );

    apb_cnn u_apb_cnn (
        .PCLK     (PCLK),
        .PRESETn  (PRESETn),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .score_in (score_in),
        .argmax   (argmax_res),
        .sat      (sat_res),
        .irq      (irq)
    );

endmodule

`default_nettype wire

// File: rtl/apb_cnn.sv
`timescale 1ns/1ps
`default_nettype none

`include "cnn_params.svh"

module apb_cnn
    import cnn_pkg::*;
(
    input  logic        PCLK,
    input  logic        PRESETn,
    input  apb_req_t    apb_req,
    output apb_rsp_t    apb_rsp,
    input  score_pkt_t  score_in,
    input  argmax_res_t argmax,
    input  sat_res_t    sat,
    output logic        irq
);

    logic [31:0] score_d;       // Raw word, aligned with the analysis results
    logic        result_valid;
    logic        accept;

    score_t      thresh;
    logic [3:0]  res_one_hot;
    logic [1:0]  res_index;
    logic [31:0] scores_reg;
    logic [15:0] acc_cnt;
    logic [15:0] rej_cnt;
    logic [3:0]  sat_mask_reg;

    logic        setup_phase;
    logic        access_phase;
    logic        rd_access;
    logic        wr_access;
    logic        hit_result;
    logic        hit_thresh;
    logic        hit_scores;
    logic        hit_count;
    logic        hit_status;
    logic        addr_mapped;
    logic        ro_write;
    logic        result_read;
    logic [31:0] rd_mux;
    logic [31:0] rd_word;

    always_ff @(posedge PCLK) begin
        if (score_in.valid) begin
            score_d <= score_in.word.raw;
        end
    end

    // Both analysis blocks run in lock step
    assign result_valid = argmax.valid & sat.valid;
    assign accept       = result_valid && (sat.lane_mask == 4'b0000) &&
                          (argmax.top >= thresh);  // Signed compare

    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            res_one_hot  <= 4'b0000;
            res_index    <= 2'd0;
            scores_reg   <= 32'd0;
            acc_cnt      <= 16'd0;
            rej_cnt      <= 16'd0;
            sat_mask_reg <= 4'b0000;
        end else if (result_valid) begin
            scores_reg   <= score_d;         // Kept for every inference
            sat_mask_reg <= sat.lane_mask;
            if (accept) begin
                res_one_hot <= argmax.one_hot;
                res_index   <= argmax.index;
                acc_cnt     <= acc_cnt + 16'd1;  // Wraps
            end else begin
                rej_cnt     <= rej_cnt + 16'd1;
            end
        end
    end

    // APB phase decode, zero wait states
    assign setup_phase  = apb_req.psel & ~apb_req.penable;
    assign access_phase = apb_req.psel &  apb_req.penable;
    assign rd_access    = access_phase & ~apb_req.pwrite;
    assign wr_access    = access_phase &  apb_req.pwrite;

    assign hit_result  = (apb_req.paddr == `CNN_REG_RESULT);
    assign hit_thresh  = (apb_req.paddr == `CNN_REG_THRESH);
    assign hit_scores  = (apb_req.paddr == `CNN_REG_SCORES);
    assign hit_count   = (apb_req.paddr == `CNN_REG_COUNT);
    assign hit_status  = (apb_req.paddr == `CNN_REG_STATUS);
    assign addr_mapped = hit_result | hit_thresh | hit_scores | hit_count | hit_status;
    assign ro_write    = apb_req.pwrite & (hit_result | hit_scores | hit_count | hit_status);

    assign result_read = rd_access & hit_result;

    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            thresh <= 8'sd0;
        end else if (wr_access && hit_thresh) begin
            thresh <= apb_req.pwdata[7:0];  // Upper bits ignored
        end
    end

    // Accept has priority over the clearing read
    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            irq <= 1'b0;
        end else if (accept) begin
            irq <= 1'b1;
        end else if (result_read) begin
            irq <= 1'b0;
        end
    end

    always_comb begin
        case (apb_req.paddr)
            `CNN_REG_RESULT: rd_mux = {22'd0, res_index, 4'd0, res_one_hot};
            `CNN_REG_THRESH: rd_mux = {24'd0, thresh};
            `CNN_REG_SCORES: rd_mux = scores_reg;
            `CNN_REG_COUNT:  rd_mux = {rej_cnt, acc_cnt};
            `CNN_REG_STATUS: rd_mux = {27'd0, irq, sat_mask_reg};
            default:         rd_mux = 32'd0;
        endcase
    end

    // Read word sampled in setup, presented in access
    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            rd_word <= 32'd0;
        end else if (setup_phase) begin
            rd_word <= rd_mux;
        end
    end

    always_comb begin
        apb_rsp.prdata  = rd_access ? rd_word : 32'd0;
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access_phase & (~addr_mapped | ro_write);
    end

endmodule

`default_nettype wire

// File: rtl/score_saturation_check.sv
`timescale 1ns/1ps
`default_nettype none

`include "cnn_params.svh"

module score_saturation_check
    import cnn_pkg::*;
(
    input  logic       PCLK,
    input  logic       PRESETn,
    input  score_pkt_t score_in,
    output sat_res_t   result
);

    logic [`CNN_NUM_CLASSES-1:0] lane_sat;
    logic                        valid_q;
    logic [`CNN_NUM_CLASSES-1:0] mask_q;

    // A lane pinned at either quantizer rail has clipped
    always_comb begin
        for (int i = 0; i < `CNN_NUM_CLASSES; i++) begin
            lane_sat[i] = (score_in.word.lane[i] == 8'sh7f) ||  // +127
                          (score_in.word.lane[i] == 8'sh80);    // -128
        end
    end

    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= score_in.valid;  // Aligned with argmax output
        end
    end

    always_ff @(posedge PCLK) begin
        if (score_in.valid) begin
            mask_q <= lane_sat;
        end
    end

    always_comb begin
        result.valid     = valid_q;
        result.lane_mask = mask_q;
    end

endmodule

`default_nettype wire

// File: rtl/gesture_argmax.sv
`timescale 1ns/1ps
`default_nettype none

`include "cnn_params.svh"

module gesture_argmax
    import cnn_pkg::*;
(
    input  logic        PCLK,
    input  logic        PRESETn,
    input  score_pkt_t  score_in,
    output argmax_res_t result
);

    score_t     best_score;
    logic [1:0] best_idx;

    logic       valid_q;
    logic [3:0] one_hot_q;
    logic [1:0] index_q;
    score_t     top_q;

    // Linear scan over the lanes
    always_comb begin
        best_score = score_in.word.lane[0];
        best_idx   = 2'd0;
        for (int i = 1; i < `CNN_NUM_CLASSES; i++) begin
            if (score_in.word.lane[i] > best_score) begin  // Strict, lower index wins a tie
                best_score = score_in.word.lane[i];
                best_idx   = 2'(i);
            end
        end
    end

    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= score_in.valid;  // One cycle behind the inference
        end
    end

    always_ff @(posedge PCLK) begin
        if (score_in.valid) begin
            one_hot_q <= 4'b0001 << best_idx;
            index_q   <= best_idx;
            top_q     <= best_score;
        end
    end

    always_comb begin
        result.valid   = valid_q;
        result.one_hot = one_hot_q;
        result.index   = index_q;
        result.top     = top_q;
    end

endmodule

`default_nettype wire

// File: rtl/cnn_pkg.sv
`default_nettype none

`include "cnn_params.svh"

package cnn_pkg;

    typedef logic signed [`CNN_SCORE_W-1:0] score_t;

    // Same word seen as raw bits or as signed lanes, lane 0 in low byte
    typedef union packed {
        logic [`CNN_NUM_CLASSES*`CNN_SCORE_W-1:0] raw;
        score_t [`CNN_NUM_CLASSES-1:0]             lane;
    } score_word_u;

    typedef struct packed {
        logic        valid;
        score_word_u word;
    } score_pkt_t;

    typedef struct packed {
        logic                                 valid;
        logic [`CNN_NUM_CLASSES-1:0]          one_hot;
        logic [$clog2(`CNN_NUM_CLASSES)-1:0]  index;
        score_t                               top;
    } argmax_res_t;

    typedef struct packed {
        logic                        valid;
        logic [`CNN_NUM_CLASSES-1:0] lane_mask;  // One bit per clipped lane
    } sat_res_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

// File: rtl/cnn_params.svh
`ifndef CNN_PARAMS_SVH
`define CNN_PARAMS_SVH

// Score stream geometry
`define CNN_NUM_CLASSES 4        // Gesture classes per inference
`define CNN_SCORE_W     8        // Bits per signed class score

// APB register map, offsets within PADDR[11:0]
`define CNN_REG_RESULT  12'h000  // Last accepted one-hot and index
`define CNN_REG_THRESH  12'h004  // Minimum top score, signed
`define CNN_REG_SCORES  12'h008  // Raw word of last inference
`define CNN_REG_COUNT   12'h00C  // Rejected and accepted counters
`define CNN_REG_STATUS  12'h010  // Saturation mask and irq

`endif
